//--- Makefile
# Verilator build, run, lint and clean for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/fetch_buffer.sv
// Fetch buffer
// Circular FIFO of fetched blocks and their addresses toward decode.
// Flush drops everything held. The free count is sampled by the sequencer
// only while no access is in flight, so a push always finds room.

`timescale 1ns/1ps
`default_nettype none

module fetch_buffer
  import fetch_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_flush,
  input  logic                     i_push,
  input  vaddr_t                   i_push_addr,
  input  fetch_blk_t               i_push_data,

  input  logic                     i_pop_ready,
  output logic                     o_valid,
  output vaddr_t                   o_pc,
  output fetch_blk_t               o_block,
  output logic [FETCH_BUF_PTR_W:0] o_free_cnt
);

  vaddr_t                     r_pc_q  [FETCH_BUF_DEPTH];
  fetch_blk_t                 r_blk_q [FETCH_BUF_DEPTH];
  logic [FETCH_BUF_PTR_W-1:0] r_wr_ptr;
  logic [FETCH_BUF_PTR_W-1:0] r_rd_ptr;
  logic [FETCH_BUF_PTR_W:0]   r_count;
  logic                       w_pop;

  assign w_pop = o_valid & i_pop_ready;

  // ============================================================
  // pointers and count
  // ============================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) r_wr_ptr <= r_wr_ptr + FETCH_BUF_PTR_W'(1);
      if (w_pop)  r_rd_ptr <= r_rd_ptr + FETCH_BUF_PTR_W'(1);
      case ({i_push, w_pop})
        2'b10   : r_count <= r_count + (FETCH_BUF_PTR_W+1)'(1);
        2'b01   : r_count <= r_count - (FETCH_BUF_PTR_W+1)'(1);
        default : r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push && !i_flush) begin
      r_pc_q[r_wr_ptr]  <= i_push_addr;
      r_blk_q[r_wr_ptr] <= i_push_data;
    end
  end

  assign o_valid    = (r_count != '0);
  assign o_pc       = r_pc_q[r_rd_ptr];
  assign o_block    = r_blk_q[r_rd_ptr];
  assign o_free_cnt = (FETCH_BUF_PTR_W+1)'(FETCH_BUF_DEPTH) - r_count;

endmodule

`default_nettype wire

//--- rtl/fetch_pc_ctrl.sv
// Fetch address sequencer
// Steps the fetch address one aligned block at a time, launches one
// memory access at a time, and decides which returning blocks are pushed
// into the fetch buffer. A redirect during an access marks the returning
// block for discard.

`timescale 1ns/1ps
`default_nettype none

module fetch_pc_ctrl
  import fetch_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_redirect_valid,
  input  vaddr_t                   i_redirect_target,

  input  logic                     i_mem_busy,
  input  logic                     i_mem_done,
  input  logic [FETCH_BUF_PTR_W:0] i_buf_free_cnt,

  output logic                     o_start,
  output vaddr_t                   o_start_addr,
  output logic                     o_push,
  output vaddr_t                   o_push_addr
);

  fetch_state_t r_state;
  fetch_state_t w_state_next;
  vaddr_t       r_fetch_pc;       // next block to fetch
  vaddr_t       w_fetch_pc_next;
  vaddr_t       r_inflight_pc;    // block currently on the memory port
  logic         r_discard;
  logic         w_discard_next;
  vaddr_t       w_redirect_blk;

  assign w_redirect_blk = {i_redirect_target[VADDR_W-1:FETCH_OFF_W], {FETCH_OFF_W{1'b0}}};

  always_comb begin
    w_state_next    = r_state;
    w_fetch_pc_next = r_fetch_pc;
    w_discard_next  = r_discard;
    o_start         = 1'b0;
    o_push          = 1'b0;

    case (r_state)
      FETCH_INIT : w_state_next = FETCH_REQ;
      FETCH_REQ : begin
        if (i_redirect_valid) begin
          w_fetch_pc_next = w_redirect_blk;
        end else if (!i_mem_busy) begin
          // previous push already counted once the port is idle
          if (i_buf_free_cnt == '0) begin
            w_state_next = FETCH_WAIT_BUF;
          end else begin
            o_start         = 1'b1;
            w_fetch_pc_next = r_fetch_pc + vaddr_t'(FETCH_BYTES);
            w_state_next    = FETCH_WAIT_MEM;
          end
        end
      end
      FETCH_WAIT_MEM : begin
        if (i_mem_done) begin
          o_push         = ~r_discard & ~i_redirect_valid;
          w_discard_next = 1'b0;
          w_state_next   = FETCH_REQ;
        end else if (i_redirect_valid) begin
          w_discard_next = 1'b1;  // stale block still coming back
        end
        if (i_redirect_valid) w_fetch_pc_next = w_redirect_blk;
      end
      FETCH_WAIT_BUF : begin
        if (i_redirect_valid) begin
          w_fetch_pc_next = w_redirect_blk;
          w_state_next    = FETCH_REQ;
        end else if (i_buf_free_cnt != '0) begin
          w_state_next = FETCH_REQ;
        end
      end
      default : w_state_next = FETCH_INIT;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= FETCH_INIT;
      r_fetch_pc <= RESET_PC;
      r_discard  <= 1'b0;
    end else begin
      r_state    <= w_state_next;
      r_fetch_pc <= w_fetch_pc_next;
      r_discard  <= w_discard_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_start) r_inflight_pc <= r_fetch_pc;
  end

  assign o_start_addr = r_fetch_pc;
  assign o_push_addr  = r_inflight_pc;

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
// Fetch front end package
// Widths, reset address, fetch buffer sizing and the enums shared by the
// fetch sequencer, redirect logic and decode-side buffer.

`default_nettype none

package fetch_pkg;

  // ============================================================
  // widths and sizes
  // ============================================================
  localparam int VADDR_W         = 32;
  localparam int XLEN            = 32;
  localparam int FETCH_BYTES     = 8;
  localparam int FETCH_OFF_W     = $clog2(FETCH_BYTES);
  localparam int FETCH_BLK_W     = FETCH_BYTES * 8;
  localparam int FETCH_BUF_DEPTH = 4;
  localparam int FETCH_BUF_PTR_W = $clog2(FETCH_BUF_DEPTH);

  typedef logic [VADDR_W-1:0]     vaddr_t;
  typedef logic [FETCH_BLK_W-1:0] fetch_blk_t;

  localparam vaddr_t RESET_PC = 32'h0000_1000;  // first fetch after reset

  // ============================================================
  // commit event types, numbered as the cause codes
  // ============================================================
  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN  = 5'd0,
    INST_ACC_FAULT      = 5'd1,
    ILLEGAL_INST        = 5'd2,
    LOAD_ADDR_MISALIGN  = 5'd4,
    LOAD_ACC_FAULT      = 5'd5,
    STAMO_ADDR_MISALIGN = 5'd6,
    STAMO_ACC_FAULT     = 5'd7,
    ECALL_U             = 5'd8,
    ECALL_S             = 5'd9,
    ECALL_M             = 5'd11,
    INST_PAGE_FAULT     = 5'd12,
    LOAD_PAGE_FAULT     = 5'd13,
    STAMO_PAGE_FAULT    = 5'd15,
    SILENT_FLUSH        = 5'd16,  // not architectural, core-internal flushes
    ANOTHER_FLUSH       = 5'd17,
    MRET                = 5'd18,
    SRET                = 5'd19
  } except_t;

  // fetch sequencer states
  typedef enum logic [2:0] {
    FETCH_INIT     = 3'd0,
    FETCH_REQ      = 3'd1,
    FETCH_WAIT_MEM = 3'd2,
    FETCH_WAIT_BUF = 3'd3
  } fetch_state_t;

endpackage

`default_nettype wire

//--- rtl/fetch_redirect.sv
// Fetch redirect select
// Decides whether the fetch stream is redirected this cycle and where to.
// Commit events (flushes, xRET, traps) take priority over a branch
// mispredict. Traps go to stvec when delegated through medeleg.

`timescale 1ns/1ps
`default_nettype none

module fetch_redirect
  import fetch_pkg::*;
(
  input  logic            i_commit_valid,
  input  except_t         i_commit_type,
  input  vaddr_t          i_commit_epc,

  input  vaddr_t          i_csr_mtvec,
  input  vaddr_t          i_csr_stvec,
  input  vaddr_t          i_csr_mepc,
  input  vaddr_t          i_csr_sepc,
  input  logic [XLEN-1:0] i_csr_medeleg,

  input  logic            i_br_mispredict,
  input  vaddr_t          i_br_target,

  output logic            o_redirect_valid,
  output vaddr_t          o_redirect_target
);

  vaddr_t w_trap_vec;
  vaddr_t w_commit_target;

  // delegated traps land in supervisor mode
  assign w_trap_vec = i_csr_medeleg[i_commit_type] ? i_csr_stvec : i_csr_mtvec;

  always_comb begin
    case (i_commit_type)
      SILENT_FLUSH  : w_commit_target = i_commit_epc + vaddr_t'(4);  // resume after
      ANOTHER_FLUSH : w_commit_target = i_commit_epc;                // replay
      MRET          : w_commit_target = i_csr_mepc;
      SRET          : w_commit_target = i_csr_sepc;
      INST_ADDR_MISALIGN, INST_ACC_FAULT, ILLEGAL_INST,
      LOAD_ADDR_MISALIGN, LOAD_ACC_FAULT,
      STAMO_ADDR_MISALIGN, STAMO_ACC_FAULT,
      ECALL_U, ECALL_S, ECALL_M,
      INST_PAGE_FAULT, LOAD_PAGE_FAULT, STAMO_PAGE_FAULT :
        w_commit_target = w_trap_vec;
      default       : w_commit_target = i_csr_mtvec;  // unknown cause, machine mode
    endcase
  end

  // ============================================================
  // commit before branch
  // ============================================================
  assign o_redirect_valid  = i_commit_valid | i_br_mispredict;
  assign o_redirect_target = i_commit_valid ? w_commit_target : i_br_target;

endmodule

`default_nettype wire

//--- rtl/frontend_top.sv
// Fetch front end top
// Redirect select, fetch sequencer, instruction memory port and fetch
// buffer, wired together.

`timescale 1ns/1ps
`default_nettype none

module frontend_top
  import fetch_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_reset_n,

  input  logic            i_commit_valid,
  input  except_t         i_commit_type,
  input  vaddr_t          i_commit_epc,

  input  vaddr_t          i_csr_mtvec,
  input  vaddr_t          i_csr_stvec,
  input  vaddr_t          i_csr_mepc,
  input  vaddr_t          i_csr_sepc,
  input  logic [XLEN-1:0] i_csr_medeleg,

  input  logic            i_br_mispredict,
  input  vaddr_t          i_br_target,

  output logic            o_mem_req,
  output vaddr_t          o_mem_addr,
  input  logic            i_mem_ack,
  input  fetch_blk_t      i_mem_rdata,

  output logic            o_fe_valid,
  output vaddr_t          o_fe_pc,
  output fetch_blk_t      o_fe_block,
  input  logic            i_fe_ready
);

  logic                     w_redirect_valid;
  vaddr_t                   w_redirect_target;
  logic                     w_start;
  vaddr_t                   w_start_addr;
  logic                     w_mem_busy;
  logic                     w_mem_done;
  fetch_blk_t               w_mem_rdata;
  logic                     w_push;
  vaddr_t                   w_push_addr;
  logic [FETCH_BUF_PTR_W:0] w_free_cnt;

  fetch_redirect u_redirect (
    .i_commit_valid   (i_commit_valid),
    .i_commit_type    (i_commit_type),
    .i_commit_epc     (i_commit_epc),
    .i_csr_mtvec      (i_csr_mtvec),
    .i_csr_stvec      (i_csr_stvec),
    .i_csr_mepc       (i_csr_mepc),
    .i_csr_sepc       (i_csr_sepc),
    .i_csr_medeleg    (i_csr_medeleg),
    .i_br_mispredict  (i_br_mispredict),
    .i_br_target      (i_br_target),
    .o_redirect_valid (w_redirect_valid),
    .o_redirect_target(w_redirect_target)
  );

  fetch_pc_ctrl u_pc_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_redirect_valid (w_redirect_valid),
    .i_redirect_target(w_redirect_target),
    .i_mem_busy       (w_mem_busy),
    .i_mem_done       (w_mem_done),
    .i_buf_free_cnt   (w_free_cnt),
    .o_start          (w_start),
    .o_start_addr     (w_start_addr),
    .o_push           (w_push),
    .o_push_addr      (w_push_addr)
  );

  imem_port u_imem_port (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_start     (w_start),
    .i_start_addr(w_start_addr),
    .o_mem_req   (o_mem_req),
    .o_mem_addr  (o_mem_addr),
    .i_mem_ack   (i_mem_ack),
    .i_mem_rdata (i_mem_rdata),
    .o_busy      (w_mem_busy),
    .o_done      (w_mem_done),
    .o_rdata     (w_mem_rdata)
  );

  fetch_buffer u_fetch_buffer (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_flush    (w_redirect_valid),  // every redirect empties it
    .i_push     (w_push),
    .i_push_addr(w_push_addr),
    .i_push_data(w_mem_rdata),
    .i_pop_ready(i_fe_ready),
    .o_valid    (o_fe_valid),
    .o_pc       (o_fe_pc),
    .o_block    (o_fe_block),
    .o_free_cnt (w_free_cnt)
  );

endmodule

`default_nettype wire

//--- rtl/imem_port.sv
// Instruction memory port
// Four-phase req/ack master. Raises req with a held address, drops it
// once ack is sampled, then waits for ack to fall before going idle.
// Read data is captured on the ack and reported with a one-cycle done.

`timescale 1ns/1ps
`default_nettype none

module imem_port
  import fetch_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,

  input  logic       i_start,
  input  vaddr_t     i_start_addr,

  output logic       o_mem_req,
  output vaddr_t     o_mem_addr,
  input  logic       i_mem_ack,
  input  fetch_blk_t i_mem_rdata,

  output logic       o_busy,
  output logic       o_done,
  output fetch_blk_t o_rdata
);

  logic       r_mem_req;
  logic       r_wait_low;   // req dropped, ack still high
  logic       r_done;
  vaddr_t     r_addr;
  fetch_blk_t r_rdata;
  logic       w_accept;

  assign w_accept = i_start & ~o_busy;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mem_req  <= 1'b0;
      r_wait_low <= 1'b0;
      r_done     <= 1'b0;
    end else begin
      r_done <= 1'b0;
      if (r_mem_req) begin
        if (i_mem_ack) begin
          r_mem_req  <= 1'b0;
          r_wait_low <= 1'b1;
          r_done     <= 1'b1;
        end
      end else if (r_wait_low) begin
        if (!i_mem_ack) r_wait_low <= 1'b0;
      end else if (w_accept) begin
        r_mem_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) r_addr <= i_start_addr;
    if (r_mem_req && i_mem_ack) r_rdata <= i_mem_rdata;
  end

  assign o_mem_req  = r_mem_req;
  assign o_mem_addr = r_addr;
  assign o_busy     = r_mem_req | r_wait_low;
  assign o_done     = r_done;
  assign o_rdata    = r_rdata;

endmodule

`default_nettype wire

//--- verification/frontend_checker.sv
// Front end protocol checker
// Concurrent assertions on the four-phase memory handshake and on the
// decode-side flush after a redirect. Bound into the front end top.

`timescale 1ns/1ps
`default_nettype none

module frontend_checker
  import fetch_pkg::*;
(
  input logic   i_clk,
  input logic   i_reset_n,
  input logic   i_mem_req,
  input vaddr_t i_mem_addr,
  input logic   i_mem_ack,
  input logic   i_redirect_valid,
  input logic   i_fe_valid
);

  // req held until the memory answers
  a_req_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_req && !i_mem_ack |=> i_mem_req)
    else $error("o_mem_req dropped before i_mem_ack was seen");

  a_addr_stable : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_req |=> !i_mem_req || $stable(i_mem_addr))
    else $error("o_mem_addr changed while o_mem_req was high");

  // ack must return low before the next request
  a_no_req_on_ack : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !i_mem_req && i_mem_ack |=> !i_mem_req)
    else $error("o_mem_req raised while i_mem_ack was still high");

  a_flush_on_redirect : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_redirect_valid |=> !i_fe_valid)
    else $error("o_fe_valid high in the cycle after a redirect");

endmodule

bind frontend_top frontend_checker u_checker (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_mem_req       (o_mem_req),
  .i_mem_addr      (o_mem_addr),
  .i_mem_ack       (i_mem_ack),
  .i_redirect_valid(w_redirect_valid),
  .i_fe_valid      (o_fe_valid)
);

`default_nettype wire

//--- verification/frontend_tb.sv
// Fetch front end testbench
// Drives the front end through reset, sequential fetch, decode stall,
// branch mispredicts and commit redirects. A memory model answers the
// req/ack port with a random delay and address-derived data.

`timescale 1ns/1ps
`default_nettype none

module frontend_tb
  import fetch_pkg::*;
;

  localparam vaddr_t DATA_PATTERN = 32'ha5c3_0f96;
  localparam vaddr_t MTVEC_VAL    = 32'h0000_8104;
  localparam vaddr_t STVEC_VAL    = 32'h0000_9200;
  localparam vaddr_t MEPC_VAL     = 32'h0000_a00e;
  localparam vaddr_t SEPC_VAL     = 32'h0000_b006;
  localparam vaddr_t EPC_VAL      = 32'h0000_c00c;
  localparam vaddr_t BR_DECOY     = 32'h0000_d000;  // loses to the commit

  // ============================================================
  // run length bound
  // ============================================================
  localparam int STALL_CYCLES      = 64;
  localparam int QUIET_CYCLES      = 16;
  localparam int ACCESS_MAX_CYCLES = 12;  // worst case with 5 ack and 2 release delays
  localparam int T1_ACCESSES       = 4;
  localparam int T2_ACCESSES       = 12;
  localparam int T3_ACCESSES       = 16;
  localparam int T4_ACCESSES       = 8;
  localparam int T5_ACCESSES       = (20 * 2 + 2) * 3;
  localparam int TIMEOUT_CYCLES    =
    (T1_ACCESSES + T2_ACCESSES + T3_ACCESSES + T4_ACCESSES + T5_ACCESSES) * ACCESS_MAX_CYCLES
    + 2 * STALL_CYCLES + 200;

  logic            clk;
  logic            reset_n;
  logic            commit_valid;
  except_t         commit_type;
  vaddr_t          commit_epc;
  vaddr_t          csr_mtvec;
  vaddr_t          csr_stvec;
  vaddr_t          csr_mepc;
  vaddr_t          csr_sepc;
  logic [XLEN-1:0] csr_medeleg;
  logic            br_mispredict;
  vaddr_t          br_target;
  logic            mem_req;
  vaddr_t          mem_addr;
  logic            mem_ack;
  fetch_blk_t      mem_rdata;
  logic            fe_valid;
  vaddr_t          fe_pc;
  fetch_blk_t      fe_block;
  logic            fe_ready;

  integer seed = 32'hc1cd26e7;
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     test_cnt = 0;
  int     cycle_cnt = 0;

  tb_clock_gen u_clock_gen (.o_clk(clk), .o_reset_n(reset_n));

  frontend_top i_dut (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_commit_valid(commit_valid), .i_commit_type(commit_type), .i_commit_epc(commit_epc),
    .i_csr_mtvec(csr_mtvec), .i_csr_stvec(csr_stvec),
    .i_csr_mepc(csr_mepc), .i_csr_sepc(csr_sepc), .i_csr_medeleg(csr_medeleg),
    .i_br_mispredict(br_mispredict), .i_br_target(br_target),
    .o_mem_req(mem_req), .o_mem_addr(mem_addr), .i_mem_ack(mem_ack), .i_mem_rdata(mem_rdata),
    .o_fe_valid(fe_valid), .o_fe_pc(fe_pc), .o_fe_block(fe_block), .i_fe_ready(fe_ready)
  );

  function automatic fetch_blk_t make_block(input vaddr_t addr);
    return {(FETCH_BLK_W / VADDR_W){addr ^ DATA_PATTERN}};
  endfunction

  function automatic vaddr_t align_block(input vaddr_t addr);
    return addr & ~vaddr_t'(FETCH_BYTES - 1);
  endfunction

  // where a commit of this cause code should send fetch
  function automatic vaddr_t expected_commit_target(input logic [4:0] code,
                                                    input logic [XLEN-1:0] deleg);
    logic is_trap;
    is_trap = except_t'(code) inside {INST_ADDR_MISALIGN, INST_ACC_FAULT, ILLEGAL_INST,
      LOAD_ADDR_MISALIGN, LOAD_ACC_FAULT, STAMO_ADDR_MISALIGN, STAMO_ACC_FAULT,
      ECALL_U, ECALL_S, ECALL_M, INST_PAGE_FAULT, LOAD_PAGE_FAULT, STAMO_PAGE_FAULT};
    if (code == SILENT_FLUSH) return EPC_VAL + vaddr_t'(4);
    if (code == ANOTHER_FLUSH) return EPC_VAL;
    if (code == MRET) return MEPC_VAL;
    if (code == SRET) return SEPC_VAL;
    if (is_trap && deleg[code]) return STVEC_VAL;
    return MTVEC_VAL;
  endfunction

  // memory model acking after 0 to 5 falling edges
  // and holding ack 0 to 2 edges past the dropped req
  initial begin : mem_responder
    int   delay_left;
    int   release_left;
    logic armed;
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    delay_left   = 0;
    release_left = 0;
    armed        = 1'b0;
    forever begin
      @(negedge clk);
      if (mem_ack) begin
        if (!mem_req) begin
          if (release_left == 0) begin
            mem_ack = 1'b0;
          end else begin
            release_left = release_left - 1;
          end
        end
      end else if (mem_req) begin
        if (!armed) begin
          delay_left = int'($unsigned($random(seed)) % 32'd6);
          armed      = 1'b1;
        end
        if (delay_left == 0) begin
          mem_ack      = 1'b1;
          mem_rdata    = make_block(mem_addr);
          release_left = int'($unsigned($random(seed)) % 32'd3);
          armed        = 1'b0;
        end else begin
          delay_left = delay_left - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: no result after %0d cycles", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // ============================================================
  // checks and reporting
  // ============================================================
  task automatic check_addr(input string name, input vaddr_t got, input vaddr_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_block(input string name, input fetch_blk_t got, input fetch_blk_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("[%0t] %s: done, %0d errors", $time, name, err_cnt - errs_before);
  endtask

  // called on a falling edge; returns on the next one after the transfer
  task automatic expect_block(input vaddr_t exp_pc);
    while (!(fe_valid && fe_ready)) @(negedge clk);
    check_addr("o_fe_pc", fe_pc, exp_pc);
    check_block("o_fe_block", fe_block, make_block(exp_pc));
    @(negedge clk);
  endtask

  task automatic expect_run(input vaddr_t start_pc, input int n);
    for (int k = 0; k < n; k++) expect_block(start_pc + vaddr_t'(FETCH_BYTES * k));
  endtask

  task automatic apply_redirect(input logic commit, input except_t kind,
                                input logic branch, input vaddr_t tgt);
    commit_valid  = commit;
    commit_type   = kind;
    br_mispredict = branch;
    br_target     = tgt;
    @(negedge clk);
    commit_valid  = 1'b0;
    br_mispredict = 1'b0;
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic test_reset();
    int errs0;
    int wait_cycles;
    errs0 = err_cnt;
    repeat (3) begin
      @(negedge clk);
      if (mem_req !== 1'b0 || fe_valid !== 1'b0)
        flag_error("o_mem_req or o_fe_valid high while reset is held");
    end
    wait (reset_n === 1'b1);
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
    end while (mem_req !== 1'b1);
    if (wait_cycles != 2) flag_error("o_mem_req did not rise two cycles after reset release");
    check_addr("o_mem_addr", mem_addr, RESET_PC);
    report_test("reset", errs0);
  endtask

  task automatic test_sequential();
    int errs0;
    errs0 = err_cnt;
    expect_run(RESET_PC, 12);
    report_test("sequential fetch", errs0);
  endtask

  task automatic test_backpressure();
    int     errs0;
    logic   req_seen;
    vaddr_t next_pc;
    errs0    = err_cnt;
    next_pc  = RESET_PC + vaddr_t'(12 * FETCH_BYTES);
    req_seen = 1'b0;
    fe_ready = 1'b0;
    for (int c = 0; c < STALL_CYCLES; c++) begin
      @(negedge clk);
      if (c >= STALL_CYCLES - QUIET_CYCLES && mem_req) req_seen = 1'b1;
    end
    if (req_seen) flag_error("o_mem_req raised while the fetch buffer was full");
    // last fetch is the fourth held block
    check_addr("o_mem_addr", mem_addr, next_pc + vaddr_t'(FETCH_BYTES * (FETCH_BUF_DEPTH - 1)));
    fe_ready = 1'b1;
    expect_run(next_pc, 12);
    report_test("back-pressure", errs0);
  endtask

  task automatic test_branch();
    int errs0;
    errs0 = err_cnt;
    while (!mem_req) @(negedge clk);  // access on the port
    apply_redirect(1'b0, ANOTHER_FLUSH, 1'b1, 32'h0000_2345);
    expect_run(align_block(32'h0000_2345), 3);
    fe_ready = 1'b0;
    repeat (STALL_CYCLES) @(negedge clk);  // buffer fills and the port goes idle
    apply_redirect(1'b0, ANOTHER_FLUSH, 1'b1, 32'h0000_3007);
    fe_ready = 1'b1;
    expect_run(align_block(32'h0000_3007), 3);
    report_test("branch mispredict", errs0);
  endtask

  task automatic test_commit();
    int     errs0;
    vaddr_t tgt;
    errs0 = err_cnt;
    for (int code = 0; code < 20; code++) begin
      for (int dele = 0; dele < 2; dele++) begin
        // own bit alone, or every bit but the own one
        csr_medeleg = (dele != 0) ? (XLEN'(1) << code) : ~(XLEN'(1) << code);
        tgt = expected_commit_target(5'(code), csr_medeleg);
        apply_redirect(1'b1, except_t'(code), 1'b0, '0);
        expect_run(align_block(tgt), 2);
      end
    end
    csr_medeleg = XLEN'(1) << ECALL_S;
    tgt = expected_commit_target(ECALL_S, csr_medeleg);
    apply_redirect(1'b1, ECALL_S, 1'b1, BR_DECOY);
    expect_run(align_block(tgt), 2);
    tgt = expected_commit_target(MRET, csr_medeleg);
    apply_redirect(1'b1, MRET, 1'b1, BR_DECOY);
    expect_run(align_block(tgt), 2);
    report_test("commit redirect", errs0);
  endtask

  initial begin
    commit_valid  = 1'b0;
    commit_type   = ANOTHER_FLUSH;
    commit_epc    = EPC_VAL;
    csr_mtvec     = MTVEC_VAL;
    csr_stvec     = STVEC_VAL;
    csr_mepc      = MEPC_VAL;
    csr_sepc      = SEPC_VAL;
    csr_medeleg   = '0;
    br_mispredict = 1'b0;
    br_target     = '0;
    fe_ready      = 1'b1;

    test_reset();
    test_sequential();
    test_backpressure();
    test_branch();
    test_commit();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock and reset
// 40 ns clock, reset held low for the first 4 cycles and
// released on a falling edge.

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge o_clk);
    o_reset_n = 1'b1;  // released away from the sampling edge
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/fetch_pkg.sv
rtl/fetch_redirect.sv
rtl/fetch_pc_ctrl.sv
rtl/imem_port.sv
rtl/fetch_buffer.sv
rtl/frontend_top.sv
verification/tb_clock_gen.sv
verification/frontend_checker.sv
verification/frontend_tb.sv
